//--- rtl/switch_msg_pkg.sv
`default_nettype none

// Message format shared by routers, arbiters and the top level.
package switch_msg_pkg;

  // Field widths.
  localparam int dest_width    = 2;   // Selects one of four ports.
  localparam int payload_width = 30;  // Rest of the 32-bit word.
  localparam int msg_width     = dest_width + payload_width;

  // Output port number, taken from the top bits of a message.
  typedef logic [dest_width-1:0] dest_t;

  // Message body, carried through untouched.
  typedef logic [payload_width-1:0] payload_t;

  // Full message word, dest in the MSBs.
  typedef struct packed {
    dest_t    dest;     // Target port.
    payload_t payload;  // Opaque to the switch.
  } msg_t;

  // Valid plus message, as seen on one router-to-arbiter link or on a port.
  typedef struct packed {
    logic val;  // Message present.
    msg_t msg;  // Broadcast copy of the message.
  } out_req_t;

endpackage

`default_nettype wire

//--- rtl/switch_cfg_pkg.sv
`default_nettype none

// Switch dimensions and default sizing.
package switch_cfg_pkg;

  // Two input streams, one router each.
  localparam int num_inputs = 2;

  // One port per dest code, so the count follows the dest field.
  localparam int num_outputs = 2 ** $bits(switch_msg_pkg::dest_t);

  // Entries per router queue.
  localparam int default_queue_depth = 3;

  // Index of an input, as held by the arbiter pointer.
  localparam int input_idx_width = (num_inputs > 1) ? $clog2(num_inputs) : 1;

  typedef logic [input_idx_width-1:0] input_idx_t;

endpackage

`default_nettype wire

//--- rtl/msg_queue.sv
`default_nettype none

// Circular buffer of messages with a valid/ready interface on both sides.
// Depth must be 2 or more.
module msg_queue #(
  parameter int queue_depth = switch_cfg_pkg::default_queue_depth
) (
  input  logic                  clk,
  input  logic                  reset,

  input  logic                  enq_val,
  input  switch_msg_pkg::msg_t  enq_msg,
  output logic                  enq_rdy,

  output logic                  deq_val,
  output switch_msg_pkg::msg_t  deq_msg,
  input  logic                  deq_rdy
);

  import switch_msg_pkg::*;

  localparam int ptr_width   = $clog2(queue_depth);
  localparam int count_width = $clog2(queue_depth + 1);

  typedef logic [ptr_width-1:0]   ptr_t;    // Slot index.
  typedef logic [count_width-1:0] count_t;  // Occupancy, 0 to queue_depth.

  msg_t   mem [queue_depth];  // Storage, no reset needed.
  ptr_t   wr_ptr;             // Next slot to write.
  ptr_t   rd_ptr;             // Current head slot.
  count_t count;              // Entries held.

  logic full;
  logic enq_fire;
  logic deq_fire;

  assign full     = (count == count_t'(queue_depth));
  assign deq_val  = (count != '0);               // No bypass, empty means invalid.
  assign deq_msg  = mem[rd_ptr];                 // Head read straight from storage.
  assign enq_rdy  = !full || deq_rdy;            // Full queue still takes one on a pop.
  assign enq_fire = enq_val && enq_rdy;
  assign deq_fire = deq_val && deq_rdy;

  // Storage write.
  always_ff @(posedge clk) begin
    if (enq_fire) begin
      mem[wr_ptr] <= enq_msg;
    end
  end

  // Pointers and count.
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq_fire) begin
        wr_ptr <= (wr_ptr == ptr_t'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap.
      end
      if (deq_fire) begin
        rd_ptr <= (rd_ptr == ptr_t'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;  // Wrap.
      end
      case ({enq_fire, deq_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither.
      endcase
    end
  end

  // Occupancy never goes past the depth.
  assert property (@(posedge clk) disable iff (reset)
    count <= count_t'(queue_depth));

  // An empty queue can only stay empty or take one, so the count never wraps.
  assert property (@(posedge clk) disable iff (reset)
    (count == '0) |=> (count <= count_t'(1)));

  // A stalled head keeps its message and its valid.
  assert property (@(posedge clk) disable iff (reset)
    deq_val && !deq_rdy |=> deq_val && $stable(deq_msg));

endmodule

`default_nettype wire

//--- rtl/router.sv
`default_nettype none

// One input stream. Queues messages and steers the head toward the port named
// by its dest field. Every port sees the message, only one sees valid.
module router #(
  parameter int queue_depth = switch_cfg_pkg::default_queue_depth
) (
  input  logic                      clk,
  input  logic                      reset,

  // Input stream.
  input  logic                      in_val,
  input  switch_msg_pkg::msg_t      in_msg,
  output logic                      in_rdy,

  // One request per output port.
  output switch_msg_pkg::out_req_t  out_req [switch_cfg_pkg::num_outputs],
  input  logic                      out_rdy [switch_cfg_pkg::num_outputs]
);

  import switch_msg_pkg::*;
  import switch_cfg_pkg::*;

  msg_t  head_msg;                   // Queue head.
  logic  head_val;
  logic  head_rdy;                   // Ready of the selected port.
  dest_t sel;                        // Port picked by the head.
  logic [num_outputs-1:0] val_vec;   // Decoded valids.
  logic [num_outputs-1:0] rdy_vec;   // Port readies, packed.

  msg_queue #(
    .queue_depth(queue_depth)
  ) i_msg_queue (
    .clk    (clk),
    .reset  (reset),
    .enq_val(in_val),
    .enq_msg(in_msg),
    .enq_rdy(in_rdy),
    .deq_val(head_val),
    .deq_msg(head_msg),
    .deq_rdy(head_rdy)
  );

  assign sel      = head_msg.dest;   // Top bits of the message.
  assign head_rdy = out_rdy[sel];    // Ready mux.

  // Valid demux, message broadcast.
  always_comb begin
    for (int o = 0; o < num_outputs; o++) begin
      val_vec[o]     = head_val && (sel == dest_t'(o));
      rdy_vec[o]     = out_rdy[o];
      out_req[o].val = val_vec[o];
      out_req[o].msg = head_msg;
    end
  end

  // Only the port that was offered the head may take it.
  assert property (@(posedge clk) disable iff (reset)
    (rdy_vec & ~val_vec) == '0);

endmodule

`default_nettype wire

//--- rtl/output_arbiter.sv
`default_nettype none

// Round-robin merge of the router requests for one output port.
// Grant is combinational, pointer moves past the winner on a transfer.
module output_arbiter (
  input  logic                      clk,
  input  logic                      reset,

  // One request per router, grant is that router's ready.
  input  switch_msg_pkg::out_req_t  req   [switch_cfg_pkg::num_inputs],
  output logic                      grant [switch_cfg_pkg::num_inputs],

  // Port side.
  output switch_msg_pkg::out_req_t  port_req,
  input  logic                      port_rdy
);

  import switch_cfg_pkg::*;

  input_idx_t ptr;                  // Highest priority input.
  input_idx_t winner;               // Input forwarded this cycle.
  input_idx_t lock_idx;             // Winner held over a stall.
  logic       locked;               // Port stalled last cycle.
  logic       found;                // Some input requests.
  logic       fire;                 // Transfer on the port.
  logic [num_inputs-1:0] grant_vec;

  // Input index a given number of steps after base, with wrap.
  function automatic input_idx_t step_idx(input input_idx_t base, input int step);
    return input_idx_t'((int'(base) + step) % num_inputs);
  endfunction

  // Pick the first requester at or after the pointer.
  always_comb begin
    found  = 1'b0;
    winner = ptr;
    if (locked) begin
      winner = lock_idx;            // Stalled choice sticks.
      found  = req[lock_idx].val;
    end else begin
      for (int k = 0; k < num_inputs; k++) begin
        if (!found && req[step_idx(ptr, k)].val) begin
          found  = 1'b1;
          winner = step_idx(ptr, k);
        end
      end
    end
  end

  assign port_req.val = found;                 // Never looks at port_rdy.
  assign port_req.msg = req[winner].msg;
  assign fire         = found && port_rdy;

  // Grant only the winner, and only when the port takes it.
  always_comb begin
    for (int i = 0; i < num_inputs; i++) begin
      grant_vec[i] = fire && (winner == input_idx_t'(i));
      grant[i]     = grant_vec[i];
    end
  end

  // Pointer and stall lock.
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr      <= '0;
      locked   <= 1'b0;
      lock_idx <= '0;
    end else begin
      if (fire) begin
        ptr <= step_idx(winner, 1);            // Winner goes to the back.
      end
      if (found && !port_rdy) begin
        locked   <= 1'b1;
        lock_idx <= winner;
      end else begin
        locked   <= 1'b0;
      end
    end
  end

  // A waiting input gets the next turn after a transfer.
  assert property (@(posedge clk) disable iff (reset)
    fire && req[step_idx(winner, 1)].val |=> winner != $past(winner));

  // A stalled port keeps the same source and message.
  assert property (@(posedge clk) disable iff (reset)
    port_req.val && !port_rdy |=>
      port_req.val && (winner == $past(winner)) && $stable(port_req.msg));

  // Routers hold valid while not granted, so a locked input still requests.
  assert property (@(posedge clk) disable iff (reset)
    locked |-> req[lock_idx].val);

endmodule

`default_nettype wire

//--- rtl/msg_switch.sv
`default_nettype none

// Two-input, four-port message switch.
// Each input has a router; each port has a round-robin arbiter.
module msg_switch #(
  parameter int queue_depth = switch_cfg_pkg::default_queue_depth
) (
  input  logic                      clk,
  input  logic                      reset,

  // Input streams.
  input  logic                      in_val   [switch_cfg_pkg::num_inputs],
  input  switch_msg_pkg::msg_t      in_msg   [switch_cfg_pkg::num_inputs],
  output logic                      in_rdy   [switch_cfg_pkg::num_inputs],

  // Output ports.
  output switch_msg_pkg::out_req_t  port_req [switch_cfg_pkg::num_outputs],
  input  logic                      port_rdy [switch_cfg_pkg::num_outputs]
);

  import switch_msg_pkg::*;
  import switch_cfg_pkg::*;

  // Router side, indexed [input][output].
  out_req_t rtr_req   [num_inputs][num_outputs];
  logic     rtr_rdy   [num_inputs][num_outputs];

  // Arbiter side, indexed [output][input].
  out_req_t arb_req   [num_outputs][num_inputs];
  logic     arb_grant [num_outputs][num_inputs];

  // One router per input stream.
  for (genvar i = 0; i < num_inputs; i++) begin : g_router
    router #(
      .queue_depth(queue_depth)
    ) i_router (
      .clk    (clk),
      .reset  (reset),
      .in_val (in_val[i]),
      .in_msg (in_msg[i]),
      .in_rdy (in_rdy[i]),
      .out_req(rtr_req[i]),
      .out_rdy(rtr_rdy[i])
    );
  end

  // Transpose requests toward the arbiters and grants back to the routers.
  for (genvar o = 0; o < num_outputs; o++) begin : g_port
    for (genvar i = 0; i < num_inputs; i++) begin : g_link
      assign arb_req[o][i] = rtr_req[i][o];
      assign rtr_rdy[i][o] = arb_grant[o][i];
    end

    output_arbiter i_output_arbiter (
      .clk     (clk),
      .reset   (reset),
      .req     (arb_req[o]),
      .grant   (arb_grant[o]),
      .port_req(port_req[o]),
      .port_rdy(port_rdy[o])
    );
  end

endmodule

`default_nettype wire

//--- sim/msg_switch_tb.sv
`default_nettype none

// Testbench for the message switch. LCG traffic, a reference router model
// and one scoreboard queue per input/output pair.
module msg_switch_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import switch_msg_pkg::*;
  import switch_cfg_pkg::*;

  localparam int queue_depth  = default_queue_depth;
  localparam int reset_cycles = 5;
  localparam int num_basic    = 16;   // Per input, all ports ready.
  localparam int num_alt      = 8;    // Per input, all to one port.
  localparam int num_stall    = 6;    // Input 0 toward the stalled port.
  localparam int num_side     = 8;    // Input 1 toward the other ports.
  localparam int num_random   = 200;  // Per input, random gaps and ready.
  localparam int total_msgs   = num_inputs * (num_basic + num_alt + num_random)
                                + num_stall + num_side;
  localparam int cycle_limit  = total_msgs * 20;
  localparam logic [31:0] seed = 32'd14983;
  localparam dest_t alt_port   = dest_t'(2);
  localparam dest_t stall_port = dest_t'(1);

  logic     clk = 1'b0;
  logic     reset;
  logic     in_val   [num_inputs];
  msg_t     in_msg   [num_inputs];
  logic     in_rdy   [num_inputs];
  out_req_t port_req [num_outputs];
  logic     port_rdy [num_outputs];

  msg_t        send_q [num_inputs][$];            // Stimulus not yet accepted.
  msg_t        sb_q [num_inputs*num_outputs][$];  // Expected, per input/output pair.
  logic        in_fire  [num_inputs];             // Accept at the coming edge.
  int          accepted [num_inputs];             // Accepted since reset.
  int          seq      [num_inputs];             // Next sequence number.
  logic        hold_low [num_outputs];            // Force port_rdy low.
  logic        random_mode;                       // Random gaps and ready.
  logic        alt_check;                         // Round-robin check on alt_port.
  logic        alt_have;
  input_idx_t  alt_last;                          // Source of the last alt_port transfer.
  logic [31:0] stim_seed;
  logic [31:0] drive_seed;
  int          errors;

  msg_switch #(
    .queue_depth(queue_depth)
  ) i_msg_switch (
    .clk     (clk),
    .reset   (reset),
    .in_val  (in_val),
    .in_msg  (in_msg),
    .in_rdy  (in_rdy),
    .port_req(port_req),
    .port_rdy(port_rdy)
  );

  always #5 clk = ~clk;  // 10 ns period.

  // Next LCG state.
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Port a message must leave on. Dest sits in the top bits of the word.
  function automatic dest_t ref_route(input msg_t m);
    logic [msg_width-1:0] word;
    word = m;
    return word[msg_width-1 -: dest_width];
  endfunction

  function automatic logic input_idle(input int i);
    logic idle;
    idle = (send_q[i].size() == 0);
    for (int o = 0; o < num_outputs; o++) begin
      idle = idle && (sb_q[i*num_outputs + o].size() == 0);
    end
    return idle;
  endfunction

  // Nothing left to send and no port offers a message.
  function automatic logic switch_idle();
    logic idle;
    idle = 1'b1;
    for (int i = 0; i < num_inputs; i++) begin
      idle = idle && (send_q[i].size() == 0) && !in_val[i];
    end
    for (int o = 0; o < num_outputs; o++) begin
      idle = idle && !port_req[o].val;
    end
    return idle;
  endfunction

  task automatic abort_run();
    $display("tests failed");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_msg(input string name, input msg_t got, input msg_t exp);
    if (got !== exp) begin
      $display("ERROR %0d ns: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_port(input string name, input dest_t got, input dest_t exp);
    if (got !== exp) begin
      $display("ERROR %0d ns: %s got %0d expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %0d ns: %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  // Top payload bit is the input number, the rest a sequence count.
  task automatic queue_msg(input int i, input dest_t d);
    msg_t m;
    m.dest    = d;
    m.payload = payload_t'(seq[i]);
    m.payload[payload_width-1] = i[0];
    seq[i]++;
    send_q[i].push_back(m);
  endtask

  task automatic queue_random(input int n);
    for (int k = 0; k < n; k++) begin
      for (int i = 0; i < num_inputs; i++) begin
        stim_seed = lcg_step(stim_seed);
        queue_msg(i, dest_t'(stim_seed[17:16]));
      end
    end
  endtask

  // Waits for the switch to go quiet; leftovers show up in the scoreboard.
  task automatic wait_drained();
    @(negedge clk);
    while (!switch_idle()) @(negedge clk);
    repeat (2) @(posedge clk);
  endtask

  // One port transfer against the reference and the scoreboard.
  task automatic check_transfer(input int o, input msg_t got);
    input_idx_t src;
    int         idx;
    msg_t       exp;
    src = input_idx_t'(got.payload[payload_width-1]);  // Tag bit names the source.
    idx = int'(src) * num_outputs + o;
    check_port($sformatf("port of message %h", got), dest_t'(o), ref_route(got));
    if (alt_check && dest_t'(o) == alt_port) begin
      if (alt_have && src == alt_last) begin
        $display("Port %0d served input %0d twice in a row at %0d ns", o, src, $time);
        abort_run();
      end else begin
        alt_have = 1'b1;
        alt_last = src;
      end
    end
    if (sb_q[idx].size() == 0) begin
      $display("Message %h left port %0d but input %0d never sent it", got, o, src);
      abort_run();
    end else begin
      exp = sb_q[idx].pop_front();  // Oldest first, so order is checked too.
      check_msg($sformatf("port_req[%0d].msg", o), got, exp);
    end
  endtask

  // Driver. Inputs change 1 ns after each rising edge.
  initial begin
    drive_seed = seed;
    for (int i = 0; i < num_inputs; i++) begin
      in_val[i] = 1'b0;
      in_msg[i] = '0;
    end
    for (int o = 0; o < num_outputs; o++) port_rdy[o] = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      for (int i = 0; i < num_inputs; i++) begin
        drive_seed = lcg_step(drive_seed);
        if (reset) begin
          in_val[i] = 1'b0;
        end else begin
          if (in_fire[i]) void'(send_q[i].pop_front());  // Taken at this edge.
          if (in_val[i] && !in_fire[i]) begin
            in_val[i] = 1'b1;                            // Held until taken.
          end else if (send_q[i].size() > 0 && (!random_mode || drive_seed[17:16] != 2'b00)) begin
            in_val[i] = 1'b1;
            in_msg[i] = send_q[i][0];
          end else begin
            in_val[i] = 1'b0;
          end
        end
      end
      for (int o = 0; o < num_outputs; o++) begin
        drive_seed  = lcg_step(drive_seed);
        port_rdy[o] = !hold_low[o] && (!random_mode || drive_seed[18]);
      end
    end
  end

  // Monitor. Samples at the falling edge, where every signal is settled.
  always @(negedge clk) begin
    if (!alt_check) alt_have = 1'b0;
    for (int i = 0; i < num_inputs; i++) begin
      in_fire[i] = !reset && in_val[i] && in_rdy[i];
      if (reset) accepted[i] = 0;
      if (in_fire[i]) begin
        accepted[i]++;
        sb_q[i*num_outputs + int'(ref_route(in_msg[i]))].push_back(in_msg[i]);
      end
    end
    for (int o = 0; o < num_outputs; o++) begin
      if (!reset && port_req[o].val && port_rdy[o]) check_transfer(o, port_req[o].msg);
    end
  end

  // Watchdog.
  initial begin
    repeat (cycle_limit + reset_cycles) @(posedge clk);
    $display("Timeout after %0d cycles with traffic still pending", cycle_limit);
    abort_run();
  end

  initial begin
    int base;
    stim_seed   = seed;
    reset       = 1'b1;
    random_mode = 1'b0;
    alt_check   = 1'b0;
    errors      = 0;
    for (int i = 0; i < num_inputs; i++) seq[i] = 0;
    for (int o = 0; o < num_outputs; o++) hold_low[o] = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1 reset = 1'b0;

    // Idle state right after reset.
    @(negedge clk);
    for (int o = 0; o < num_outputs; o++) begin
      check_flag($sformatf("port_req[%0d].val", o), port_req[o].val, 1'b0);
    end
    for (int i = 0; i < num_inputs; i++) begin
      check_flag($sformatf("in_rdy[%0d]", i), in_rdy[i], 1'b1);
    end

    // Routing and per-pair order with every port ready.
    @(posedge clk);
    queue_random(num_basic);
    wait_drained();

    // Both inputs compete for one port.
    alt_check = 1'b1;
    for (int k = 0; k < num_alt; k++) begin
      queue_msg(0, alt_port);
      queue_msg(1, alt_port);
    end
    wait_drained();
    alt_check = 1'b0;

    // Back-pressure on one port while the other input keeps flowing.
    hold_low[stall_port] = 1'b1;
    base = accepted[0];
    for (int k = 0; k < num_stall; k++) queue_msg(0, stall_port);
    for (int k = 0; k < num_side; k++) begin
      stim_seed = lcg_step(stim_seed);
      queue_msg(1, (dest_t'(stim_seed[17:16]) == stall_port) ? dest_t'(0)
                                                             : dest_t'(stim_seed[17:16]));
    end
    while (!input_idle(1)) @(posedge clk);
    repeat (4) @(posedge clk);
    @(negedge clk);
    // Router and arbiter store nothing, so only the queue fills.
    if (accepted[0] - base != queue_depth) begin
      $display("Input 0 took %0d messages for a stalled port, expected %0d",
               accepted[0] - base, queue_depth);
      abort_run();
    end
    check_flag("in_rdy[0]", in_rdy[0], 1'b0);
    @(posedge clk);
    hold_low[stall_port] = 1'b0;
    wait_drained();

    // Random gaps and random port ready.
    random_mode = 1'b1;
    queue_random(num_random);
    wait_drained();
    random_mode = 1'b0;

    for (int p = 0; p < num_inputs * num_outputs; p++) begin
      if (sb_q[p].size() != 0) begin
        $display("Input %0d still owes %0d messages to port %0d",
                 p / num_outputs, sb_q[p].size(), p % num_outputs);
        errors++;
      end
    end
    if (errors == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

`default_nettype wire

//--- switch.f
rtl/switch_msg_pkg.sv
rtl/switch_cfg_pkg.sv
rtl/msg_queue.sv
rtl/router.sv
rtl/output_arbiter.sv
rtl/msg_switch.sv
sim/msg_switch_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the message switch testbench with Verilator and run it.
# The simulator exits non-zero on $fatal, which stops the script.
set -e

cd "$(dirname "$0")"

top=msg_switch_tb
exe=msg_switch_sim

verilator --binary --timing --assert \
  -f switch.f \
  --top-module "$top" \
  -o "$exe"

./obj_dir/"$exe"
